//--- Bender.yml
package:
  name: booth_mul

dependencies: {}

sources:
  - hdl/mul_pkg.sv
  - hdl/booth_encoder.sv
  - hdl/pp_gen_stage.sv
  - hdl/compressor42.sv
  - hdl/wallace_stage.sv
  - hdl/cla_stage.sv
  - hdl/booth_mul_top.sv
  - target: simulation
    files:
      - testbench/tb_booth_mul.sv

//--- hdl/booth_encoder.sv
`timescale 1ns/100ps

module booth_encoder (
    input  logic [mul_pkg::MUL_WIDTH-1:0] multiplicand_i,
    input  logic [2:0]                    window_i,
    output logic [mul_pkg::MUL_WIDTH:0]   row_o
);

    mul_pkg::booth_sel_e sel;

    logic [mul_pkg::MUL_WIDTH:0] m_single;
    logic [mul_pkg::MUL_WIDTH:0] m_double;

    // one extra bit so that negating the most negative operand stays exact
    assign m_single = {multiplicand_i[mul_pkg::MUL_WIDTH-1], multiplicand_i};
    assign m_double = {multiplicand_i, 1'b0};

    // window is {b[2k+1], b[2k], b[2k-1]}
    always_comb begin
        case (window_i)
            3'b001,
            3'b010:  sel = mul_pkg::BOOTH_POS1;
            3'b011:  sel = mul_pkg::BOOTH_POS2;
            3'b100:  sel = mul_pkg::BOOTH_NEG2;
            3'b101,
            3'b110:  sel = mul_pkg::BOOTH_NEG1;
            default: sel = mul_pkg::BOOTH_ZERO;
        endcase
    end

    always_comb begin
        case (sel)
            mul_pkg::BOOTH_POS1: begin
                row_o = m_single;
            end
            mul_pkg::BOOTH_POS2: begin
                row_o = m_double;
            end
            // full two's-complement negation
            mul_pkg::BOOTH_NEG1: begin
                row_o = ~m_single + 1'b1;
            end
            mul_pkg::BOOTH_NEG2: begin
                row_o = ~m_double + 1'b1;
            end
            default: begin
                row_o = '0;
            end
        endcase
    end

endmodule

//--- hdl/booth_mul_top.sv
`timescale 1ns/100ps

module booth_mul_top (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  mul_pkg::mul_req_t req_i,
    output mul_pkg::mul_rsp_t rsp_o
);

    mul_pkg::pp_bundle_t pp;
    mul_pkg::csa_pair_t  pair;

    // stage 1: Booth rows
    pp_gen_stage i_pp_gen_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .pp_o     (pp)
    );

    // stage 2: Wallace tree down to one sum/carry pair
    wallace_stage i_wallace_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .pp_i     (pp),
        .pair_o   (pair)
    );

    // stage 3: final carry-lookahead add
    cla_stage i_cla_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .pair_i   (pair),
        .rsp_o    (rsp_o)
    );

endmodule

//--- hdl/cla_stage.sv
`timescale 1ns/100ps

module cla_stage (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  mul_pkg::csa_pair_t pair_i,
    output mul_pkg::mul_rsp_t  rsp_o
);

    localparam int GROUPS = mul_pkg::PROD_WIDTH / 4;
    localparam int SUPERS = GROUPS / 4;

    // per bit
    logic [mul_pkg::PROD_WIDTH-1:0] bit_g;
    logic [mul_pkg::PROD_WIDTH-1:0] bit_p;
    logic [mul_pkg::PROD_WIDTH-1:0] bit_c;

    // per 4-bit group, and per block of four groups
    logic [GROUPS-1:0] grp_g;
    logic [GROUPS-1:0] grp_p;
    logic [GROUPS-1:0] grp_c;
    logic [SUPERS-1:0] sup_g;
    logic [SUPERS-1:0] sup_p;
    logic [SUPERS-1:0] sup_c;

    mul_pkg::mul_rsp_t rsp_q;

    // carries into each of four positions, fully flattened
    function automatic logic [3:0] carries4(input logic [3:0] g, input logic [3:0] p,
                                            input logic cin);
        logic [3:0] c;
        c[0] = cin;
        c[1] = g[0] | (p[0] & cin);
        c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
        c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);
        return c;
    endfunction

    function automatic logic gen4(input logic [3:0] g, input logic [3:0] p);
        return g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0]);
    endfunction

    assign bit_g = pair_i.sum & pair_i.carry;
    assign bit_p = pair_i.sum ^ pair_i.carry;

    always_comb begin
        for (int j = 0; j < GROUPS; j++) begin
            grp_g[j] = gen4(bit_g[4*j +: 4], bit_p[4*j +: 4]);
            grp_p[j] = &bit_p[4*j +: 4];
        end
        for (int s = 0; s < SUPERS; s++) begin
            sup_g[s] = gen4(grp_g[4*s +: 4], grp_p[4*s +: 4]);
            sup_p[s] = &grp_p[4*s +: 4];
        end

        // top-level lookahead, carry-in is zero
        sup_c = carries4(sup_g, sup_p, 1'b0);

        for (int s = 0; s < SUPERS; s++) begin
            grp_c[4*s +: 4] = carries4(grp_g[4*s +: 4], grp_p[4*s +: 4], sup_c[s]);
        end
        for (int j = 0; j < GROUPS; j++) begin
            bit_c[4*j +: 4] = carries4(bit_g[4*j +: 4], bit_p[4*j +: 4], grp_c[j]);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q.valid   <= pair_i.valid;
            rsp_q.product <= bit_p ^ bit_c;
        end
    end

    assign rsp_o = rsp_q;

endmodule

//--- hdl/compressor42.sv
`timescale 1ns/100ps

module compressor42 (
    input  logic [mul_pkg::PROD_WIDTH-1:0] in1_i,
    input  logic [mul_pkg::PROD_WIDTH-1:0] in2_i,
    input  logic [mul_pkg::PROD_WIDTH-1:0] in3_i,
    input  logic [mul_pkg::PROD_WIDTH-1:0] in4_i,
    output logic [mul_pkg::PROD_WIDTH-1:0] sum_o,
    output logic [mul_pkg::PROD_WIDTH-1:0] carry_o
);

    // first full adder per bit
    logic [mul_pkg::PROD_WIDTH-1:0] fa1_sum;
    logic [mul_pkg::PROD_WIDTH-1:0] fa1_cout;

    // carry entering each bit from the bit below, zero into bit 0
    logic [mul_pkg::PROD_WIDTH-1:0] chain_in;

    // second full adder per bit, carry not yet shifted
    logic [mul_pkg::PROD_WIDTH-1:0] fa2_cout;

    always_comb begin
        for (int i = 0; i < mul_pkg::PROD_WIDTH; i++) begin
            fa1_sum[i]  = in1_i[i] ^ in2_i[i] ^ in3_i[i];
            fa1_cout[i] = (in1_i[i] & in2_i[i]) | (in1_i[i] & in3_i[i]) |
                          (in2_i[i] & in3_i[i]);
        end
    end

    // chained carry out of bit 63 falls off the top (modulo 2^64)
    assign chain_in = {fa1_cout[mul_pkg::PROD_WIDTH-2:0], 1'b0};

    always_comb begin
        for (int i = 0; i < mul_pkg::PROD_WIDTH; i++) begin
            sum_o[i]    = fa1_sum[i] ^ in4_i[i] ^ chain_in[i];
            fa2_cout[i] = (fa1_sum[i] & in4_i[i]) | (fa1_sum[i] & chain_in[i]) |
                          (in4_i[i] & chain_in[i]);
        end
    end

    // carry weighs one bit more than sum
    assign carry_o = {fa2_cout[mul_pkg::PROD_WIDTH-2:0], 1'b0};

endmodule

//--- hdl/mul_pkg.sv
package mul_pkg;

    // operand and product widths
    localparam int MUL_WIDTH  = 32;
    localparam int PROD_WIDTH = 2 * MUL_WIDTH;

    // one radix-4 Booth row per pair of multiplier bits
    localparam int PP_ROWS = MUL_WIDTH / 2;

    // digit selected by one 3-bit multiplier window
    typedef enum logic [2:0] {
        BOOTH_ZERO,
        BOOTH_POS1,
        BOOTH_POS2,
        BOOTH_NEG1,
        BOOTH_NEG2
    } booth_sel_e;

    typedef struct packed {
        logic                 valid;
        logic [MUL_WIDTH-1:0] a;
        logic [MUL_WIDTH-1:0] b;
    } mul_req_t;

    // rows are already shifted into position and sign-extended
    typedef struct packed {
        logic                                valid;
        logic [PP_ROWS-1:0][PROD_WIDTH-1:0] rows;
    } pp_bundle_t;

    // carry already carries the same weight as sum
    typedef struct packed {
        logic                  valid;
        logic [PROD_WIDTH-1:0] sum;
        logic [PROD_WIDTH-1:0] carry;
    } csa_pair_t;

    typedef struct packed {
        logic                  valid;
        logic [PROD_WIDTH-1:0] product;
    } mul_rsp_t;

endpackage

//--- hdl/pp_gen_stage.sv
`timescale 1ns/100ps

module pp_gen_stage (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  mul_pkg::mul_req_t   req_i,
    output mul_pkg::pp_bundle_t pp_o
);

    localparam int EXT_BITS = mul_pkg::PROD_WIDTH - mul_pkg::MUL_WIDTH - 1;

    // multiplier with an implicit zero below bit 0
    logic [mul_pkg::MUL_WIDTH:0] b_ext;

    logic [mul_pkg::MUL_WIDTH:0]  booth_row [mul_pkg::PP_ROWS];
    logic [mul_pkg::PP_ROWS-1:0]  row_sign;

    logic [mul_pkg::PP_ROWS-1:0][mul_pkg::PROD_WIDTH-1:0] rows_d;

    mul_pkg::pp_bundle_t pp_q;

    assign b_ext = {req_i.b, 1'b0};

    genvar k;
    generate
        for (k = 0; k < mul_pkg::PP_ROWS; k++) begin : g_row
            logic [2:0] window;

            assign window = b_ext[2*k+2:2*k];

            booth_encoder i_booth_encoder (
                .multiplicand_i (req_i.a),
                .window_i       (window),
                .row_o          (booth_row[k])
            );

            // sign of the row taken from the operand and the digit, not from
            // bit 32: -2 * (-2^31) = 2^32 sets bit 32 but is positive
            assign row_sign[k] = (|booth_row[k]) & (req_i.a[mul_pkg::MUL_WIDTH-1] ^ window[2]);

            // extend to the product width, then move to weight 4^k
            assign rows_d[k] = {{EXT_BITS{row_sign[k]}}, booth_row[k]} << (2 * k);
        end
    endgenerate

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pp_q <= '0;
        end else begin
            pp_q.valid <= req_i.valid;
            pp_q.rows  <= rows_d;
        end
    end

    assign pp_o = pp_q;

endmodule

//--- hdl/wallace_stage.sv
`timescale 1ns/100ps

module wallace_stage (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  mul_pkg::pp_bundle_t pp_i,
    output mul_pkg::csa_pair_t  pair_o
);

    localparam int L1_CNT = mul_pkg::PP_ROWS / 4;
    localparam int L2_CNT = L1_CNT / 2;

    // level 1 outputs, 8 vectors
    logic [mul_pkg::PROD_WIDTH-1:0] l1_sum   [L1_CNT];
    logic [mul_pkg::PROD_WIDTH-1:0] l1_carry [L1_CNT];

    // level 2 outputs, 4 vectors
    logic [mul_pkg::PROD_WIDTH-1:0] l2_sum   [L2_CNT];
    logic [mul_pkg::PROD_WIDTH-1:0] l2_carry [L2_CNT];

    // level 3 output, the final pair
    logic [mul_pkg::PROD_WIDTH-1:0] l3_sum;
    logic [mul_pkg::PROD_WIDTH-1:0] l3_carry;

    mul_pkg::csa_pair_t pair_q;

    genvar j;
    generate
        // 16 rows -> 8
        for (j = 0; j < L1_CNT; j++) begin : g_level1
            compressor42 i_compressor42 (
                .in1_i   (pp_i.rows[4*j]),
                .in2_i   (pp_i.rows[4*j+1]),
                .in3_i   (pp_i.rows[4*j+2]),
                .in4_i   (pp_i.rows[4*j+3]),
                .sum_o   (l1_sum[j]),
                .carry_o (l1_carry[j])
            );
        end

        // 8 -> 4
        for (j = 0; j < L2_CNT; j++) begin : g_level2
            compressor42 i_compressor42 (
                .in1_i   (l1_sum[2*j]),
                .in2_i   (l1_carry[2*j]),
                .in3_i   (l1_sum[2*j+1]),
                .in4_i   (l1_carry[2*j+1]),
                .sum_o   (l2_sum[j]),
                .carry_o (l2_carry[j])
            );
        end
    endgenerate

    // 4 -> 2
    compressor42 i_compressor42_l3 (
        .in1_i   (l2_sum[0]),
        .in2_i   (l2_carry[0]),
        .in3_i   (l2_sum[1]),
        .in4_i   (l2_carry[1]),
        .sum_o   (l3_sum),
        .carry_o (l3_carry)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pair_q <= '0;
        end else begin
            pair_q.valid <= pp_i.valid;
            pair_q.sum   <= l3_sum;
            pair_q.carry <= l3_carry;
        end
    end

    assign pair_o = pair_q;

endmodule

//--- sources.f
hdl/mul_pkg.sv
hdl/booth_encoder.sv
hdl/pp_gen_stage.sv
hdl/compressor42.sv
hdl/wallace_stage.sv
hdl/cla_stage.sv
hdl/booth_mul_top.sv
testbench/tb_booth_mul.sv

//--- testbench/tb_booth_mul.sv
`timescale 1ns/100ps

module tb_booth_mul;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int LATENCY      = 3;
    localparam int DRAIN_CYCLES = LATENCY + 2;
    localparam int BTB_REQS     = 200;
    localparam int SPARSE_REQS  = 60;
    localparam int MAX_GAP      = 3;

    // reset + corners + digits + back-to-back + sparse + one drain per test
    localparam int RUN_CYCLES = 2 * RESET_CYCLES + 7 + 32 + BTB_REQS +
                                SPARSE_REQS * (MAX_GAP + 1) + 5 * DRAIN_CYCLES;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 50;

    logic              clk_i;
    logic              arst_n_i;
    mul_pkg::mul_req_t req_i;
    mul_pkg::mul_rsp_t rsp_o;

    // scoreboard with one entry per request in flight
    mul_pkg::mul_rsp_t exp_q  [$];
    string             name_q [$];
    int                sent_q [$];

    // rising edges seen so far
    int cyc;

    mul_pkg::mul_rsp_t mon_exp;
    string             mon_name;
    int                mon_sent;

    booth_mul_top i_booth_mul_top (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .rsp_o    (rsp_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // reference model as a plain signed multiply in 64 bits
    function automatic logic [mul_pkg::PROD_WIDTH-1:0] signed_product(
        input logic [mul_pkg::MUL_WIDTH-1:0] a,
        input logic [mul_pkg::MUL_WIDTH-1:0] b
    );
        longint sa;
        longint sb;
        sa = $signed(a);
        sb = $signed(b);
        return sa * sb;
    endfunction

    task automatic check_product(input string name, input mul_pkg::mul_rsp_t exp_rsp,
                                 input mul_pkg::mul_rsp_t act_rsp);
        if (act_rsp !== exp_rsp) begin
            $display("ERROR %s: expected valid=%0b product=%h, actual valid=%0b product=%h",
                     name, exp_rsp.valid, exp_rsp.product, act_rsp.valid, act_rsp.product);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_valid(input string name, input logic exp_bit, input logic act_bit);
        if (act_bit !== exp_bit) begin
            $display("ERROR %s: expected rsp valid %0b, actual %0b", name, exp_bit, act_bit);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_latency(input string name, input int exp_cycles, input int act_cycles);
        if (act_cycles != exp_cycles) begin
            $display("ERROR %s: expected latency %0d cycles, actual %0d cycles",
                     name, exp_cycles, act_cycles);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // rsp_o still holds the value from before this edge's register update
    always @(posedge clk_i) begin
        if (rsp_o.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("response with valid high at cycle %0d but no request outstanding",
                         cyc);
                $display("Test failed");
                $fatal(1, "unexpected response");
            end else begin
                mon_exp  = exp_q.pop_front();
                mon_name = name_q.pop_front();
                mon_sent = sent_q.pop_front();
                check_product(mon_name, mon_exp, rsp_o);
                check_latency(mon_name, LATENCY, cyc - mon_sent);
            end
        end
        cyc = cyc + 1;
    end

    task automatic drive_request(input string name,
                                 input logic [mul_pkg::MUL_WIDTH-1:0] a,
                                 input logic [mul_pkg::MUL_WIDTH-1:0] b);
        mul_pkg::mul_rsp_t exp_rsp;
        @(negedge clk_i);
        req_i.valid = 1'b1;
        req_i.a     = a;
        req_i.b     = b;
        exp_rsp.valid   = 1'b1;
        exp_rsp.product = signed_product(a, b);
        exp_q.push_back(exp_rsp);
        name_q.push_back(name);
        // the rising edge that samples this request still sees the same count
        sent_q.push_back(cyc);
    endtask

    // operands keep moving while valid is low
    task automatic drive_idle();
        @(negedge clk_i);
        req_i.valid = 1'b0;
        req_i.a     = $urandom;
        req_i.b     = $urandom;
    endtask

    task automatic flush_pipeline();
        drive_idle();
        repeat (DRAIN_CYCLES - 1) @(negedge clk_i);
    endtask

    task automatic test_reset();
        repeat (RESET_CYCLES) begin
            @(negedge clk_i);
            check_valid("test_reset", 1'b0, rsp_o.valid);
        end
        arst_n_i = 1'b1;
        repeat (4) begin
            drive_idle();
            check_valid("test_reset", 1'b0, rsp_o.valid);
        end
    endtask

    task automatic test_corners();
        drive_request("test_corners", 32'h0000_0000, 32'hDEAD_BEEF);
        drive_request("test_corners", 32'h1234_5678, 32'h0000_0000);
        drive_request("test_corners", 32'h0000_0001, 32'hFFFF_FFFF);
        drive_request("test_corners", 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        // (-2^31)^2 = 2^62
        drive_request("test_corners", 32'h8000_0000, 32'h8000_0000);
        drive_request("test_corners", 32'h8000_0000, 32'h7FFF_FFFF);
        drive_request("test_corners", 32'h7FFF_FFFF, 32'h7FFF_FFFF);
        flush_pipeline();
    endtask

    task automatic test_booth_digits();
        logic [mul_pkg::MUL_WIDTH-1:0] mults [8];
        logic [mul_pkg::MUL_WIDTH-1:0] cands [4];
        // 55555555 gives BOOTH_POS1 in every window
        // AAAAAAAA gives BOOTH_NEG2 in window 0 and BOOTH_NEG1 above
        // 33333333 alternates BOOTH_NEG1 and BOOTH_POS1
        // CCCCCCCC has BOOTH_ZERO in window 0, then BOOTH_NEG1 and BOOTH_POS1
        // 66666666 and 99999999 mostly alternate BOOTH_POS2 and BOOTH_NEG2
        // 00000000 is BOOTH_ZERO everywhere
        // FFFFFFFF has BOOTH_NEG1 in window 0 and BOOTH_ZERO above
        mults = '{32'h5555_5555, 32'hAAAA_AAAA, 32'h3333_3333, 32'hCCCC_CCCC,
                  32'h6666_6666, 32'h9999_9999, 32'h0000_0000, 32'hFFFF_FFFF};
        cands = '{32'h1234_5678, 32'hEDCB_A988, 32'h7FFF_FFFF, 32'h8000_0000};
        foreach (mults[i]) begin
            foreach (cands[j]) begin
                drive_request("test_booth_digits", cands[j], mults[i]);
            end
        end
        flush_pipeline();
    endtask

    task automatic test_back_to_back();
        repeat (BTB_REQS) begin
            drive_request("test_back_to_back", $urandom, $urandom);
        end
        flush_pipeline();
    endtask

    task automatic test_sparse_valid();
        int gap;
        repeat (SPARSE_REQS) begin
            gap = $urandom_range(MAX_GAP, 0);
            repeat (gap) drive_idle();
            drive_request("test_sparse_valid", $urandom, $urandom);
        end
        flush_pipeline();
    endtask

    initial begin
        void'($urandom(32'h9898933e));
        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        req_i    = '0;
        cyc      = 0;

        test_reset();
        test_corners();
        test_booth_digits();
        test_back_to_back();
        test_sparse_valid();

        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived", exp_q.size());
            $display("Test failed");
            $fatal(1, "missing responses");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule
